//--- compile.f
rtl/coco_pkg.sv
rtl/address_decoder.sv
rtl/memory_array.sv
rtl/pia_port_b.sv
rtl/bus_controller.sv
rtl/coco_bus_top.sv
verification/tb_coco_bus.sv

//--- rtl/address_decoder.sv
// pure combinational map; exactly one select bit is high for any address
`timescale 1ns/1ps

module address_decoder
  import coco_pkg::*;
(
  input  addr_t    bus_addr,
  output dev_sel_t dev_sel
);

  always_comb
  begin
    dev_sel = '0;
    // ranges are disjoint, the chain only keeps it one-hot for sure
    if (bus_addr <= RAM_TOP)
    begin
      dev_sel[DEV_RAM] = 1'b1; // 32k dram
    end
    else if (bus_addr >= EXT_ROM_BASE && bus_addr < BASIC_ROM_BASE)
    begin
      dev_sel[DEV_EXT_ROM] = 1'b1; // 8000-9fff
    end
    else if (bus_addr >= BASIC_ROM_BASE && bus_addr < CART_BASE)
    begin
      dev_sel[DEV_BASIC_ROM] = 1'b1; // a000-bfff
    end
    else if (bus_addr >= CART_BASE && bus_addr <= CART_TOP)
    begin
      dev_sel[DEV_CART] = 1'b1; // cartridge slot
    end
    else if (bus_addr >= PIA_BASE && bus_addr <= PIA_TOP)
    begin
      dev_sel[DEV_PIA] = 1'b1; // pia 1, port b side only
    end
    else
    begin
      // ff00 pia, ff40 fdc, sam regs and vectors all land here
      dev_sel[DEV_NONE] = 1'b1;
    end
  end

endmodule

//--- rtl/bus_controller.sv
// apb slave for byte transfers; master must hold inputs until pready, no back-to-back overlap
`timescale 1ns/1ps

module bus_controller
  import coco_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  logic     turbo,
  input  logic     psel,
  input  logic     penable,
  input  logic     pwrite,
  input  addr_t    paddr,
  input  byte_t    pwdata,
  output byte_t    prdata,
  output logic     pready,
  output logic     pslverr,
  output addr_t    bus_addr,
  output byte_t    wdata,
  output logic     ram_we,
  output logic     pia_we,
  input  dev_sel_t dev_sel,
  input  byte_t    mem_rdata,
  input  byte_t    pia_rdata
);

  typedef enum logic [1:0] {
    IDLE,
    WAIT_TICK,
    RESPOND
  } ctrl_state_e;

  ctrl_state_e state;
  logic [$clog2(DIV_NORMAL)-1:0] div_cnt;
  logic [$clog2(DIV_NORMAL)-1:0] div_max;
  logic bus_tick; // cpu e-clock stand-in
  logic write_q;
  logic err_q;
  logic tick_hit; // transfer served on this cycle
  logic rom_hit;

  // divide by 4, or by 2 in turbo
  assign div_max  = turbo ? ($clog2(DIV_NORMAL))'(DIV_TURBO - 1)
                          : ($clog2(DIV_NORMAL))'(DIV_NORMAL - 1);
  assign bus_tick = (div_cnt >= div_max);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      div_cnt <= '0;
    else if (bus_tick)
      div_cnt <= '0; // also catches a turbo switch mid count
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // address and data captured in the setup phase
  always_ff @(posedge clk)
  begin
    if (state == IDLE && psel && !penable)
    begin
      bus_addr <= paddr;
      wdata    <= pwdata;
    end
  end

  assign tick_hit = (state == WAIT_TICK) && bus_tick;
  assign rom_hit  = dev_sel[DEV_EXT_ROM] | dev_sel[DEV_BASIC_ROM] | dev_sel[DEV_CART];

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state   <= IDLE;
      write_q <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
        begin
          if (psel && !penable)
          begin
            write_q <= pwrite;
            state   <= WAIT_TICK;
          end
        end
        WAIT_TICK:
        begin
          if (bus_tick)
          begin
            err_q <= write_q & rom_hit; // read-only region
            state <= RESPOND;
          end
        end
        default: state <= IDLE; // one response cycle
      endcase
    end
  end

  // strobes only on the tick, none for rom or unmapped space
  assign ram_we = tick_hit & write_q & dev_sel[DEV_RAM];
  assign pia_we = tick_hit & write_q & dev_sel[DEV_PIA];

  assign pready  = (state == RESPOND);
  assign pslverr = (state == RESPOND) & err_q;

  always_comb
  begin
    unique case (1'b1)
      dev_sel[DEV_PIA]:  prdata = pia_rdata;
      dev_sel[DEV_NONE]: prdata = OPEN_BUS; // floating bus
      default:           prdata = mem_rdata; // ram, roms, cart
    endcase
  end

endmodule

//--- rtl/coco_bus_top.sv
// bus subsystem only; cpu, video, sound dac and disk are outside this block
`timescale 1ns/1ps

module coco_bus_top
  import coco_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  logic  turbo,
  input  logic  dragon64,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  byte_t pwdata,
  output byte_t prdata,
  output logic  pready,
  output logic  pslverr,
  input  logic  dl_active,
  input  logic  dl_index,
  input  logic  dl_wr,
  input  addr_t dl_addr,
  input  byte_t dl_data,
  output byte_t port_b_out,
  output logic  sound_bit,
  output logic  rom_alt_bank
);

  addr_t    bus_addr;
  byte_t    wdata;
  logic     ram_we;
  logic     pia_we;
  dev_sel_t dev_sel;
  byte_t    mem_rdata;
  byte_t    pia_rdata;

  address_decoder u_address_decoder (
    .bus_addr (bus_addr),
    .dev_sel  (dev_sel)
  );

  memory_array u_memory_array (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_addr     (bus_addr),
    .dev_sel      (dev_sel),
    .wdata        (wdata),
    .ram_we       (ram_we),
    .rom_alt_bank (rom_alt_bank), // from pia pin 2
    .dl_active    (dl_active),
    .dl_index     (dl_index),
    .dl_wr        (dl_wr),
    .dl_addr      (dl_addr),
    .dl_data      (dl_data),
    .mem_rdata    (mem_rdata)
  );

  pia_port_b u_pia_port_b (
    .clk          (clk),
    .reset_n      (reset_n),
    .bus_addr     (bus_addr),
    .wdata        (wdata),
    .pia_we       (pia_we),
    .dragon64     (dragon64),
    .pia_rdata    (pia_rdata),
    .port_b_out   (port_b_out),
    .sound_bit    (sound_bit),
    .rom_alt_bank (rom_alt_bank)
  );

  bus_controller u_bus_controller (
    .clk       (clk),
    .reset_n   (reset_n),
    .turbo     (turbo),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .bus_addr  (bus_addr),
    .wdata     (wdata),
    .ram_we    (ram_we),
    .pia_we    (pia_we),
    .dev_sel   (dev_sel),
    .mem_rdata (mem_rdata),
    .pia_rdata (pia_rdata)
  );

endmodule

//--- rtl/coco_pkg.sv
// shared widths and address map; FF00 and FF40 device ranges are not decoded
package coco_pkg;

  typedef logic [15:0] addr_t; // cpu bus address
  typedef logic [7:0]  byte_t; // data byte
  typedef logic [5:0]  dev_sel_t; // one-hot device select

  // bit positions inside dev_sel_t
  typedef enum logic [2:0] {
    DEV_RAM       = 3'd0,
    DEV_EXT_ROM   = 3'd1,
    DEV_BASIC_ROM = 3'd2,
    DEV_CART      = 3'd3,
    DEV_PIA       = 3'd4,
    DEV_NONE      = 3'd5
  } dev_idx_e;

  // sam style map
  localparam addr_t RAM_TOP        = 16'h7FFF;
  localparam addr_t EXT_ROM_BASE   = 16'h8000; // extended basic
  localparam addr_t BASIC_ROM_BASE = 16'hA000; // color basic
  localparam addr_t CART_BASE      = 16'hC000;
  localparam addr_t CART_TOP       = 16'hFEFF;
  localparam addr_t PIA_BASE       = 16'hFF20; // second pia, mirrored
  localparam addr_t PIA_TOP        = 16'hFF3F;

  localparam int ROM_BANK_BYTES = 16384; // one dragon 64 bank
  localparam int CART_BYTES     = 16384;

  // a cart download must end past this offset to count
  localparam addr_t CART_MIN_END = 16'h0100;
  localparam byte_t OPEN_BUS     = 8'hFF; // floating bus reads high

  localparam int DIV_NORMAL = 4; // bus enable divisors
  localparam int DIV_TURBO  = 2;

  localparam int PIA_CTRL_DDR_BIT = 2; // 1 = data reg, 0 = ddr
  localparam int BANK_PIN         = 2; // dragon 64 rom bank pin
  localparam int SND_PIN          = 1; // single bit sound

endpackage

//--- rtl/memory_array.sv
// stores have no reset and come up undefined; reads are one cycle late
`timescale 1ns/1ps

module memory_array
  import coco_pkg::*;
(
  input  logic     clk,
  input  logic     reset_n,
  input  addr_t    bus_addr,
  input  dev_sel_t dev_sel,
  input  byte_t    wdata,
  input  logic     ram_we,
  input  logic     rom_alt_bank,
  input  logic     dl_active,
  input  logic     dl_index,
  input  logic     dl_wr,
  input  addr_t    dl_addr,
  input  byte_t    dl_data,
  output byte_t    mem_rdata
);

  byte_t ram_mem   [0:RAM_TOP];
  byte_t rom_bank0 [0:ROM_BANK_BYTES-1]; // normal dragon 64 rom
  byte_t rom_bank1 [0:ROM_BANK_BYTES-1]; // alternate rom
  byte_t cart_mem  [0:CART_BYTES-1];

  logic [$clog2(ROM_BANK_BYTES)-1:0] rom_off; // 8000 maps to 0
  logic [$clog2(CART_BYTES)-1:0]     cart_off;
  logic [$clog2(ROM_BANK_BYTES)-1:0] dl_rom_off;
  logic [$clog2(CART_BYTES)-1:0]     dl_cart_off;

  byte_t    ram_q, rom0_q, rom1_q, cart_q; // per store read regs
  dev_sel_t sel_q; // select aligned with read data
  logic     alt_q;
  logic     dl_active_d;
  logic     cart_present;

  assign rom_off     = bus_addr[$clog2(ROM_BANK_BYTES)-1:0];
  assign cart_off    = bus_addr[$clog2(CART_BYTES)-1:0];
  assign dl_rom_off  = dl_addr[$clog2(ROM_BANK_BYTES)-1:0];
  assign dl_cart_off = dl_addr[$clog2(CART_BYTES)-1:0];

  // cpu side, ram is the only writable store
  always_ff @(posedge clk)
  begin
    if (ram_we)
      ram_mem[bus_addr[14:0]] <= wdata;
    ram_q  <= ram_mem[bus_addr[14:0]];
    rom0_q <= rom_bank0[rom_off];
    rom1_q <= rom_bank1[rom_off];
    cart_q <= cart_mem[cart_off];
    sel_q  <= dev_sel;
    alt_q  <= rom_alt_bank;
  end

  // download side, index 0 boot image spans both banks
  always_ff @(posedge clk)
  begin
    if (dl_wr)
    begin
      if (dl_index)
        cart_mem[dl_cart_off] <= dl_data;
      else if (dl_addr < ROM_BANK_BYTES)
        rom_bank0[dl_rom_off] <= dl_data;
      else
        rom_bank1[dl_rom_off] <= dl_data; // upper 16k
    end
  end

  // cart counts as inserted only if the image went past 0x100
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      dl_active_d  <= 1'b0;
      cart_present <= 1'b0;
    end
    else
    begin
      dl_active_d <= dl_active;
      if (dl_active_d && !dl_active && dl_index) // end of cart load
        cart_present <= (dl_addr > CART_MIN_END);
    end
  end

  always_comb
  begin
    unique case (1'b1)
      sel_q[DEV_RAM]:       mem_rdata = ram_q;
      sel_q[DEV_EXT_ROM],
      sel_q[DEV_BASIC_ROM]: mem_rdata = alt_q ? rom1_q : rom0_q;
      sel_q[DEV_CART]:      mem_rdata = cart_present ? cart_q : OPEN_BUS; // empty slot
      default:              mem_rdata = OPEN_BUS;
    endcase
  end

endmodule

//--- rtl/pia_port_b.sv
// port b half of pia 1 only; no cb1/cb2 lines and no interrupt flags
`timescale 1ns/1ps

module pia_port_b
  import coco_pkg::*;
(
  input  logic  clk,
  input  logic  reset_n,
  input  addr_t bus_addr,
  input  byte_t wdata,
  input  logic  pia_we,
  input  logic  dragon64,
  output byte_t pia_rdata,
  output byte_t port_b_out,
  output logic  sound_bit,
  output logic  rom_alt_bank
);

  byte_t      data_reg; // output register
  byte_t      ddr_reg; // 1 = pin driven
  logic [5:0] ctrl_reg; // crb, irq flag bits not kept
  byte_t      pins;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      data_reg <= '0;
      ddr_reg  <= '0; // all inputs, pins float high
      ctrl_reg <= '0;
    end
    else if (pia_we)
    begin
      case (bus_addr[1:0])
        2'd2:
        begin
          if (ctrl_reg[PIA_CTRL_DDR_BIT])
            data_reg <= wdata;
          else
            ddr_reg <= wdata;
        end
        2'd3:    ctrl_reg <= wdata[5:0];
        default: ; // port a side dropped
      endcase
    end
  end

  // undriven pins sit on pull-ups
  assign pins = (data_reg & ddr_reg) | ~ddr_reg;

  always_comb
  begin
    case (bus_addr[1:0])
      2'd2:    pia_rdata = ctrl_reg[PIA_CTRL_DDR_BIT] ? pins : ddr_reg;
      2'd3:    pia_rdata = {2'b00, ctrl_reg};
      default: pia_rdata = OPEN_BUS;
    endcase
  end

  assign port_b_out   = pins;
  assign sound_bit    = pins[SND_PIN];
  assign rom_alt_bank = dragon64 & ~pins[BANK_PIN]; // low pin picks alt rom
endmodule

//--- verification/tb_coco_bus.sv
// needs sva support; stores are only read where written or downloaded, they power up undefined
`timescale 1ns/1ps

module tb_coco_bus
  import coco_pkg::*;
;

  localparam int TIMEOUT = 20; // cycles allowed per apb wait

  logic  clk;
  logic  reset_n;
  logic  turbo, dragon64;
  logic  psel, penable, pwrite;
  addr_t paddr;
  byte_t pwdata;
  byte_t prdata;
  logic  pready, pslverr;
  logic  dl_active, dl_index, dl_wr;
  addr_t dl_addr;
  byte_t dl_data;
  byte_t port_b_out;
  logic  sound_bit, rom_alt_bank;

  // scoreboard copies of every store
  byte_t      ram_m  [0:32767];
  byte_t      rom0_m [0:16383];
  byte_t      rom1_m [0:16383];
  byte_t      cart_m [0:16383];
  logic       cart_in_m; // cart counted as inserted
  byte_t      ddr_m, data_m;
  logic [5:0] ctrl_m;

  byte_t       exp_rdata; // expected on the pready cycle
  logic        exp_err;
  logic        chk_data; // reads only
  logic [31:0] seed;
  int          errors;
  int          xfers;
  addr_t       addr_q [$]; // ram addresses written so far

  coco_bus_top u_dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 100 mhz
  end

  // response checks sampled at the edge that ends the transfer
  rdata_ok: assert property (@(posedge clk) disable iff (!reset_n)
    (pready && chk_data) |-> (prdata == exp_rdata))
  else
  begin
    errors++;
    $display("Error at %0t: prdata expected %h, got %h", $time, exp_rdata, $sampled(prdata));
  end

  slverr_ok: assert property (@(posedge clk) disable iff (!reset_n)
    pready |-> (pslverr == exp_err))
  else
  begin
    errors++;
    $display("Error at %0t: pslverr expected %b, got %b", $time, exp_err, $sampled(pslverr));
  end

  ready_pulse: assert property (@(posedge clk) disable iff (!reset_n) pready |=> !pready)
  else
  begin
    errors++;
    $display("Error at %0t: pready stayed high for two cycles in a row", $time);
  end

  function automatic byte_t lcg_byte();
    seed = seed * 32'd1103515245 + 32'd12345;
    return seed[23:16]; // middle bits since low ones cycle fast
  endfunction

  function automatic byte_t pin_view();
    return data_m | ~ddr_m; // inputs float high
  endfunction

  function automatic logic alt_bank_expected();
    byte_t p;
    p = pin_view();
    return dragon64 && !p[2];
  endfunction

  function automatic byte_t expected_read(input addr_t a);
    if (a <= 16'h7FFF)
      return ram_m[a[14:0]];
    else if (a <= 16'hBFFF)
      return alt_bank_expected() ? rom1_m[a[13:0]] : rom0_m[a[13:0]];
    else if (a <= 16'hFEFF)
      return cart_in_m ? cart_m[a[13:0]] : 8'hFF; // empty slot
    else if (a >= 16'hFF20 && a <= 16'hFF3F && a[1:0] == 2'd2)
      return ctrl_m[2] ? pin_view() : ddr_m;
    else if (a >= 16'hFF20 && a <= 16'hFF3F && a[1:0] == 2'd3)
      return {2'b00, ctrl_m};
    return 8'hFF; // open bus
  endfunction

  task automatic end_run();
    $display("transfers: %0d, errors: %0d", xfers, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  endtask

  task automatic check_value(input string name, input byte_t expected, input byte_t actual);
    assert (actual === expected)
    else
    begin
      errors++;
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_pins();
    byte_t p;
    p = pin_view();
    check_value("port_b_out", p, port_b_out);
    check_value("sound_bit", {7'd0, p[1]}, {7'd0, sound_bit});
    check_value("rom_alt_bank", {7'd0, alt_bank_expected()}, {7'd0, rom_alt_bank});
  endtask

  // one apb transfer from setup to pready
  task automatic apb_xfer(input logic wr, input addr_t a, input byte_t d);
    int cycles;
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = wr;
    paddr     = a;
    pwdata    = d;
    chk_data  = !wr;
    exp_rdata = expected_read(a);
    exp_err   = wr && a >= 16'h8000 && a <= 16'hFEFF; // rom and cart read-only
    @(posedge clk);
    #1;
    penable = 1'b1;
    cycles  = 1;
    while (!pready && cycles < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!pready)
    begin
      errors++;
      $display("transfer to %h timed out, pready never came", a);
      end_run();
    end
    else
    begin
      assert (cycles <= DIV_NORMAL + 1)
      else
      begin
        errors++;
        $display("Error at %0t: latency expected <= %0d, got %0d",
                 $time, DIV_NORMAL + 1, cycles);
      end
      @(posedge clk); // completing edge
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      xfers++;
    end
  endtask

  task automatic apb_write(input addr_t a, input byte_t d);
    apb_xfer(1'b1, a, d);
    if (a <= 16'h7FFF)
      ram_m[a[14:0]] = d;
    else if (a >= 16'hFF20 && a <= 16'hFF3F && a[1:0] == 2'd3)
      ctrl_m = d[5:0];
    else if (a >= 16'hFF20 && a <= 16'hFF3F && a[1:0] == 2'd2)
    begin
      if (ctrl_m[2])
        data_m = d;
      else
        ddr_m = d; // ddr while control bit clear
    end
  endtask

  task automatic apb_read(input addr_t a);
    apb_xfer(1'b0, a, 8'h00);
  endtask

  // one byte per cycle with dl_addr held on the last offset as dl_active drops
  task automatic download(input logic idx, input int count);
    byte_t d;
    dl_active = 1'b1;
    dl_index  = idx;
    for (int i = 0; i < count; i++)
    begin
      d       = lcg_byte();
      dl_wr   = 1'b1;
      dl_addr = i[15:0];
      dl_data = d;
      if (idx)
        cart_m[i[13:0]] = d;
      else if (i < 16384)
        rom0_m[i[13:0]] = d;
      else
        rom1_m[i[13:0]] = d; // upper half goes to the alt bank
      @(posedge clk);
      #1;
    end
    dl_wr = 1'b0;
    @(posedge clk);
    #1;
    dl_active = 1'b0;
    if (idx)
      cart_in_m = (count - 1) > 16'h0100;
    repeat (2) @(posedge clk);
    #1;
  endtask

  task automatic rom_reads(input int n);
    addr_t a;
    for (int i = 0; i < n; i++)
    begin
      a = {lcg_byte(), lcg_byte()};
      apb_read({2'b10, a[13:0]}); // 8000-bfff
      a[15:14] = 2'b11;
      if (a > 16'hFEFF)
        a[8] = 1'b0; // keep inside the cart window
      apb_read(a);
    end
  endtask

  initial
  begin
    addr_t a;
    seed      = 32'd74;
    errors    = 0;
    xfers     = 0;
    reset_n   = 1'b0;
    turbo     = 1'b0;
    dragon64  = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    dl_active = 1'b0;
    dl_index  = 1'b0;
    dl_wr     = 1'b0;
    dl_addr   = '0;
    dl_data   = '0;
    cart_in_m = 1'b0;
    ddr_m     = '0;
    data_m    = '0;
    ctrl_m    = '0;
    exp_rdata = '0;
    exp_err   = 1'b0;
    chk_data  = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_value("pready", 8'h00, {7'd0, pready});
    check_value("pslverr", 8'h00, {7'd0, pslverr});
    check_pins(); // all pins pulled high
    for (int i = 0; i < 64; i++)
    begin
      turbo = i[5]; // second half turbo
      a     = {lcg_byte(), lcg_byte()} & 16'h7FFF;
      apb_write(a, lcg_byte());
      addr_q.push_back(a);
    end
    foreach (addr_q[j])
    begin
      turbo = j[0]; // swap divisor mid run
      apb_read(addr_q[j]);
    end
    turbo = 1'b0;
    apb_read(16'hC000); // no cart yet
    download(1'b0, 32768);
    download(1'b1, 16384);
    rom_reads(16);
    apb_write(16'h8123, 8'h5A);
    apb_write(16'hA456, 8'hC3);
    apb_write(16'hC010, 8'h99); // cart present so a stray write would show
    apb_read(16'h8123);
    apb_read(16'hA456);
    apb_read(16'hC010);
    download(1'b1, 16'h81); // last offset 0x80 is too short
    rom_reads(4);
    apb_write(16'hFF00, 8'h12); // unmapped write dropped silently
    apb_read(16'hFF00);
    apb_read(16'hFF45);
    apb_read(16'hFF80);
    apb_write(16'hFF22, 8'h36); // ddr drives pins 1, 2, 4 and 5
    apb_read(16'hFF22);
    check_pins();
    apb_write(16'hFF23, 8'h04);
    apb_read(16'hFF23);
    for (int i = 0; i < 4; i++)
    begin
      apb_write(16'hFF22, lcg_byte());
      apb_read(16'hFF22);
      check_pins();
    end
    dragon64 = 1'b1;
    apb_write(16'hFF22, 8'h02); // pin 2 low and sound high
    check_pins();
    rom_reads(8);
    apb_write(16'hFF22, 8'h04);
    check_pins();
    rom_reads(8);
    dragon64 = 1'b0; // bank pin low but no dragon 64
    apb_write(16'hFF22, 8'h00);
    check_pins();
    rom_reads(8);
    end_run();
  end

endmodule
